//--- verilog/uart_bank_pkg.sv
/*
 Shared constants and types for the UART transmit bank.
 FIFO_DEPTH must be a power of two, because the FIFO pointers wrap naturally.
 CLOCKS_PER_BIT is fixed at build time and has no runtime control.
*/

package uart_bank_pkg;

	// Bank size.
	localparam int CHANNEL_COUNT = 4;

	// Per-channel queue depth in bytes.
	localparam int FIFO_DEPTH = 8;

	// Serial bit period in clock cycles.
	localparam int CLOCKS_PER_BIT = 16;

	// Derived FIFO widths.
	localparam int FIFO_ADDR_WIDTH = $clog2(FIFO_DEPTH);
	localparam int FIFO_COUNT_WIDTH = $clog2(FIFO_DEPTH + 1);

	// Channel number.
	typedef logic [1:0] channel_index_t;

	// One bit per channel.
	typedef logic [CHANNEL_COUNT-1:0] channel_mask_t;

	// One data byte.
	typedef logic [7:0] byte_t;

	// Bit divider, counts up to CLOCKS_PER_BIT.
	typedef logic [4:0] bit_count_t;

	// FIFO pointer and occupancy.
	typedef logic [FIFO_ADDR_WIDTH-1:0] fifo_addr_t;
	typedef logic [FIFO_COUNT_WIDTH-1:0] fifo_count_t;

endpackage

//--- verilog/byte_fifo.sv
/*
 First-word-fall-through byte FIFO; the head byte is valid while not empty.
 A write when full or a read when empty is ignored, so callers gate on the flags.
*/

module byte_fifo (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_write,
	input  uart_bank_pkg::byte_t i_wdata,
	input  logic                 i_read,
	output uart_bank_pkg::byte_t o_rdata,
	output logic                 o_empty,
	output logic                 o_full
);
	import uart_bank_pkg::*;

	byte_t       mem [FIFO_DEPTH];
	fifo_addr_t  wr_ptr;
	fifo_addr_t  rd_ptr;
	fifo_count_t count;
	logic        do_write;
	logic        do_read;

	assign do_write = i_write && !o_full;
	assign do_read = i_read && !o_empty;

	assign o_empty = (count == '0);
	assign o_full = (count == fifo_count_t'(FIFO_DEPTH));

	// Head of queue, no read latency.
	assign o_rdata = mem[rd_ptr];

	// Storage.
	always_ff @(posedge i_clock) begin
		if (do_write) begin
			mem[wr_ptr] <= i_wdata;
		end
	end

	// Pointers and occupancy.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_write) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_read) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Simultaneous push and pop leave the count alone.
			case ({do_write, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// The serializer only pops a queue that holds a byte.
	a_no_read_when_empty: assert property (
		@(posedge i_clock) disable iff (i_reset) i_read |-> !o_empty);

	// The channel drops writes to a full queue before they get here.
	a_no_write_when_full: assert property (
		@(posedge i_clock) disable iff (i_reset) i_write |-> !o_full);

endmodule

//--- verilog/uart_tx_channel.sv
/*
 One 8N1 transmit channel: byte queue plus serializer.
 A frame is 10 bit periods; at least one idle cycle separates queued frames.
 Writes to a full queue are dropped and reported on o_dropped.
*/

module uart_tx_channel (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_write,
	input  uart_bank_pkg::byte_t i_data,
	output logic                 o_tx,
	output logic                 o_busy,
	output logic                 o_done,
	output logic                 o_dropped
);
	import uart_bank_pkg::*;

	typedef enum logic [1:0] {
		TX_IDLE,
		TX_START,
		TX_DATA,
		TX_STOP
	} tx_state_t;

	tx_state_t  state;
	bit_count_t bit_count;
	logic [2:0] bit_index;
	byte_t      shift;
	logic       bit_end;
	logic       fifo_write;
	logic       fifo_read;
	byte_t      fifo_rdata;
	logic       fifo_empty;
	logic       fifo_full;

	// Accept only while there is room.
	assign fifo_write = i_write && !fifo_full;

	// Pop the head as soon as the line is idle.
	assign fifo_read = (state == TX_IDLE) && !fifo_empty;

	assign bit_end = (bit_count == bit_count_t'(CLOCKS_PER_BIT - 1));

	assign o_busy = (state != TX_IDLE) || !fifo_empty;

	byte_fifo tx_fifo (
		.i_clock (i_clock),
		.i_reset (i_reset),
		.i_write (fifo_write),
		.i_wdata (i_data),
		.i_read  (fifo_read),
		.o_rdata (fifo_rdata),
		.o_empty (fifo_empty),
		.o_full  (fifo_full)
	);

	// Overflow report.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_dropped <= 1'b0;
		end else begin
			o_dropped <= i_write && fifo_full;
		end
	end

	// Serializer FSM.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= TX_IDLE;
			bit_count <= '0;
			bit_index <= '0;
			o_tx <= 1'b1;
			o_done <= 1'b0;
		end else begin
			o_done <= 1'b0;
			if (state == TX_IDLE) begin
				bit_count <= '0;
				if (fifo_read) begin
					state <= TX_START;
					o_tx <= 1'b0;
				end
			end else if (!bit_end) begin
				bit_count <= bit_count + 1'b1;
			end else begin
				bit_count <= '0;
				case (state)
					TX_START: begin
						state <= TX_DATA;
						bit_index <= '0;
						o_tx <= shift[0];
					end
					TX_DATA: begin
						if (bit_index == 3'd7) begin
							state <= TX_STOP;
							o_tx <= 1'b1;
						end else begin
							bit_index <= bit_index + 1'b1;
							o_tx <= shift[0];
						end
					end
					TX_STOP: begin
						state <= TX_IDLE;
						// Queue drained with this frame.
						o_done <= fifo_empty;
					end
					default: begin
						state <= TX_IDLE;
						o_tx <= 1'b1;
					end
				endcase
			end
		end
	end

	// Shift register, LSB goes out first.
	always_ff @(posedge i_clock) begin
		if (fifo_read) begin
			shift <= fifo_rdata;
		end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
			shift <= shift >> 1;
		end
	end

	a_idle_line_high: assert property (
		@(posedge i_clock) disable iff (i_reset) (state == TX_IDLE) |-> o_tx);

endmodule

//--- verilog/write_decoder.sv
/*
 Registers a host write and steers it to one channel.
 Strobe and byte appear one cycle after the host write.
*/

module write_decoder (
	input  logic                          i_clock,
	input  logic                          i_reset,
	input  logic                          i_write,
	input  uart_bank_pkg::channel_index_t i_channel,
	input  uart_bank_pkg::byte_t          i_data,
	output uart_bank_pkg::channel_mask_t  o_write_mask,
	output uart_bank_pkg::byte_t          o_data
);
	import uart_bank_pkg::*;

	// One-hot strobe.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_write_mask <= '0;
		end else if (i_write) begin
			o_write_mask <= channel_mask_t'(1) << i_channel;
		end else begin
			o_write_mask <= '0;
		end
	end

	// Shared byte for all channels.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			o_data <= i_data;
		end
	end

	// Each host write reaches exactly the addressed channel next cycle.
	a_strobe_one_hot: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_write |=> $onehot(o_write_mask) && o_write_mask[$past(i_channel)]);

	a_channel_in_range: assert property (
		@(posedge i_clock) disable iff (i_reset)
		i_write |-> (int'(i_channel) < CHANNEL_COUNT));

endmodule

//--- verilog/status_collector.sv
/*
 Sticky per-channel done and dropped flags.
 A clear removes the masked bits; a pulse in the same cycle keeps its bit set.
*/

module status_collector (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  uart_bank_pkg::channel_mask_t i_done,
	input  uart_bank_pkg::channel_mask_t i_dropped,
	input  logic                         i_clear,
	input  uart_bank_pkg::channel_mask_t i_clear_mask,
	output uart_bank_pkg::channel_mask_t o_done_flags,
	output uart_bank_pkg::channel_mask_t o_dropped_flags
);
	import uart_bank_pkg::*;

	channel_mask_t clear_bits;

	// Only a clear strobe applies the mask.
	assign clear_bits = i_clear ? i_clear_mask : '0;

	// Set wins over clear.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_done_flags <= '0;
			o_dropped_flags <= '0;
		end else begin
			o_done_flags <= (o_done_flags & ~clear_bits) | i_done;
			o_dropped_flags <= (o_dropped_flags & ~clear_bits) | i_dropped;
		end
	end

endmodule

//--- verilog/uart_tx_bank.sv
/*
 Bank of UART transmit channels behind one byte-write port.
 Writes are never refused; overflow shows up in o_dropped_flags.
*/

module uart_tx_bank (
	input  logic                          i_clock,
	input  logic                          i_reset,
	input  logic                          i_write,
	input  uart_bank_pkg::channel_index_t i_channel,
	input  uart_bank_pkg::byte_t          i_data,
	input  logic                          i_clear,
	input  uart_bank_pkg::channel_mask_t  i_clear_mask,
	output uart_bank_pkg::channel_mask_t  o_tx,
	output uart_bank_pkg::channel_mask_t  o_busy,
	output uart_bank_pkg::channel_mask_t  o_done_flags,
	output uart_bank_pkg::channel_mask_t  o_dropped_flags
);
	import uart_bank_pkg::*;

	channel_mask_t write_mask;
	byte_t         write_data;
	channel_mask_t done;
	channel_mask_t dropped;

	write_decoder decoder (
		.i_clock      (i_clock),
		.i_reset      (i_reset),
		.i_write      (i_write),
		.i_channel    (i_channel),
		.i_data       (i_data),
		.o_write_mask (write_mask),
		.o_data       (write_data)
	);

	// One serializer per channel.
	for (genvar ch = 0; ch < CHANNEL_COUNT; ch++) begin : g_channel
		uart_tx_channel channel (
			.i_clock   (i_clock),
			.i_reset   (i_reset),
			.i_write   (write_mask[ch]),
			.i_data    (write_data),
			.o_tx      (o_tx[ch]),
			.o_busy    (o_busy[ch]),
			.o_done    (done[ch]),
			.o_dropped (dropped[ch])
		);
	end

	status_collector collector (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_done          (done),
		.i_dropped       (dropped),
		.i_clear         (i_clear),
		.i_clear_mask    (i_clear_mask),
		.o_done_flags    (o_done_flags),
		.o_dropped_flags (o_dropped_flags)
	);

endmodule

//--- sim/uart_tx_bank_tb.sv
/*
 Trace-driven testbench for uart_tx_bank. Run it from the project root so
 that sim/uart_bank_trace.txt is found. Each F line in the trace ends one part.
*/

module uart_tx_bank_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import uart_bank_pkg::*;

	logic           i_clock;
	logic           i_reset;
	logic           i_write;
	channel_index_t i_channel;
	byte_t          i_data;
	logic           i_clear;
	channel_mask_t  i_clear_mask;
	channel_mask_t  tx;
	channel_mask_t  busy;
	channel_mask_t  done_flags;
	channel_mask_t  dropped_flags;

	// Parsed trace and the bytes each serial line still owes.
	byte_t cmd_q [$];
	int    arg_a_q [$];
	int    arg_b_q [$];
	byte_t exp_q [CHANNEL_COUNT][$];

	int cycle_count = 0;
	int cycle_limit = 0;
	int error_count = 0;
	int frame_count = 0;
	int part_count = 0;

	uart_tx_bank dut0 (
		.i_clock         (i_clock),
		.i_reset         (i_reset),
		.i_write         (i_write),
		.i_channel       (i_channel),
		.i_data          (i_data),
		.i_clear         (i_clear),
		.i_clear_mask    (i_clear_mask),
		.o_tx            (tx),
		.o_busy          (busy),
		.o_done_flags    (done_flags),
		.o_dropped_flags (dropped_flags)
	);

	always #4 i_clock = ~i_clock;

	// Run limit from the trace length.
	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count > cycle_limit) begin
			$display("timeout: no result after %0d cycles", cycle_limit);
			$display("test failed");
			$finish;
		end
	end

	task automatic load_trace();
		int               fd;
		byte_t            cmd;
		int               a;
		int               b;
		int               idle_sum = 0;
		int               frames = 0;
		logic [8*160-1:0] rest;
		fd = $fopen("sim/uart_bank_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/uart_bank_trace.txt");
			error_count++;
			return;
		end
		while ($fscanf(fd, " %c", cmd) == 1) begin
			a = 0;
			b = 0;
			if (cmd == "#") begin
				void'($fgets(rest, fd));
				continue;
			end else if (cmd == "I") begin
				void'($fscanf(fd, "%d", a));
				idle_sum += a;
			end else if (cmd == "C") begin
				void'($fscanf(fd, "%h", a));
			end else if (cmd == "W" || cmd == "E" || cmd == "F") begin
				void'($fscanf(fd, "%h %h", a, b));
				if (cmd == "E") begin
					frames++;
				end
			end else begin
				$display("unknown trace command '%c'", cmd);
				error_count++;
			end
			cmd_q.push_back(cmd);
			arg_a_q.push_back(a);
			arg_b_q.push_back(b);
		end
		$fclose(fd);
		cycle_limit = idle_sum + 12 * CLOCKS_PER_BIT * frames + 500;
	endtask

	task automatic wait_clock_falls(input bit_count_t n);
		bit_count_t k;
		for (k = '0; k < n; k++) begin
			@(negedge i_clock);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge i_clock);
			i_write <= 1'b0;
			i_clear <= 1'b0;
		end
	endtask

	task automatic write_byte(input int channel, input int data);
		@(posedge i_clock);
		i_write <= 1'b1;
		i_channel <= channel_index_t'(channel);
		i_data <= byte_t'(data);
		i_clear <= 1'b0;
	endtask

	task automatic clear_flags(input int mask);
		@(posedge i_clock);
		i_write <= 1'b0;
		i_clear <= 1'b1;
		i_clear_mask <= channel_mask_t'(mask);
	endtask

	task automatic check_reset_state();
		if (tx !== '1) begin
			$display("** Error: o_tx expected 0x%h got 0x%h", 4'hf, tx);
			error_count++;
		end
		if (busy !== '0) begin
			$display("** Error: o_busy expected 0x0 got 0x%h", busy);
			error_count++;
		end
		if (done_flags !== '0 || dropped_flags !== '0) begin
			$display("** Error: o_done_flags/o_dropped_flags expected 0x0/0x0 got 0x%h/0x%h",
				done_flags, dropped_flags);
			error_count++;
		end
		$display("reset state checked: %0d errors", error_count);
	endtask

	// Waits for all channels to go quiet, then compares the sticky flags.
	task automatic check_flags(input int want_done, input int want_dropped);
		int errors_before;
		errors_before = error_count;
		idle_cycles(4);
		@(negedge i_clock);
		while (busy != '0) begin
			@(negedge i_clock);
		end
		idle_cycles(2);
		@(negedge i_clock);
		if (done_flags !== channel_mask_t'(want_done)) begin
			$display("** Error: o_done_flags expected 0x%h got 0x%h",
				channel_mask_t'(want_done), done_flags);
			error_count++;
		end
		if (dropped_flags !== channel_mask_t'(want_dropped)) begin
			$display("** Error: o_dropped_flags expected 0x%h got 0x%h",
				channel_mask_t'(want_dropped), dropped_flags);
			error_count++;
		end
		for (int ch = 0; ch < CHANNEL_COUNT; ch++) begin
			if (exp_q[ch].size() != 0) begin
				$display("channel %0d went idle with %0d expected bytes never sent",
					ch, exp_q[ch].size());
				error_count++;
				exp_q[ch].delete();
			end
		end
		part_count++;
		$display("part %0d finished at cycle %0d: done 0x%h dropped 0x%h, %0d errors",
			part_count, cycle_count, done_flags, dropped_flags, error_count - errors_before);
	endtask

	// Serial receivers, sampling near each bit centre.
	for (genvar ch = 0; ch < CHANNEL_COUNT; ch++) begin : g_monitor
		initial begin : rx
			byte_t rx_byte;
			byte_t want;
			@(negedge i_reset);
			forever begin
				@(negedge tx[ch]);
				wait_clock_falls(bit_count_t'(CLOCKS_PER_BIT / 2));
				if (tx[ch] !== 1'b0) begin
					$display("** Error: o_tx[%0d] start bit expected 0x0 got 0x%h", ch, tx[ch]);
					error_count++;
				end
				rx_byte = '0;
				repeat (8) begin
					wait_clock_falls(bit_count_t'(CLOCKS_PER_BIT));
					rx_byte = {tx[ch], rx_byte[7:1]};
				end
				wait_clock_falls(bit_count_t'(CLOCKS_PER_BIT));
				if (tx[ch] !== 1'b1) begin
					$display("** Error: o_tx[%0d] stop bit expected 0x1 got 0x%h", ch, tx[ch]);
					error_count++;
				end
				frame_count++;
				if (exp_q[ch].size() == 0) begin
					$display("channel %0d sent byte 0x%h that the trace did not expect",
						ch, rx_byte);
					error_count++;
				end else begin
					want = exp_q[ch].pop_front();
					if (rx_byte !== want) begin
						$display("** Error: o_tx[%0d] frame data expected 0x%h got 0x%h",
							ch, want, rx_byte);
						error_count++;
					end
				end
			end
		end
	end

	initial begin
		i_clock = 1'b0;
		i_reset = 1'b1;
		i_write = 1'b0;
		i_channel = '0;
		i_data = '0;
		i_clear = 1'b0;
		i_clear_mask = '0;
		load_trace();
		repeat (8) @(posedge i_clock);
		i_reset <= 1'b0;
		@(negedge i_clock);
		check_reset_state();
		for (int i = 0; i < cmd_q.size(); i++) begin
			case (cmd_q[i])
				"W": write_byte(arg_a_q[i], arg_b_q[i]);
				"E": exp_q[arg_a_q[i]].push_back(byte_t'(arg_b_q[i]));
				"I": idle_cycles(arg_a_q[i]);
				"C": clear_flags(arg_a_q[i]);
				"F": check_flags(arg_a_q[i], arg_b_q[i]);
				default: ;
			endcase
		end
		idle_cycles(1);
		$display("summary: %0d parts, %0d frames received, %0d errors",
			part_count, frame_count, error_count);
		if (error_count == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- sim/uart_bank_trace.txt
# Columns: command letter, then arguments in hex (I takes a decimal cycle count).
# W channel byte, E channel byte, I cycles, C clear_mask, F done_flags dropped_flags
W 0 a5
E 0 a5
F 1 0
W 1 01
W 1 80
W 1 3c
E 1 01
E 1 80
E 1 3c
F 3 0
W 0 11
W 1 22
W 2 33
W 3 44
W 0 55
W 2 66
E 0 11
E 1 22
E 2 33
E 3 44
E 0 55
E 2 66
F f 0
C 5
I 30
F a 0
W 2 c0
W 2 c1
W 2 c2
W 2 c3
W 2 c4
W 2 c5
W 2 c6
W 2 c7
W 2 c8
W 2 c9
W 2 ca
E 2 c0
E 2 c1
E 2 c2
E 2 c3
E 2 c4
E 2 c5
E 2 c6
E 2 c7
E 2 c8
F e 4
C f
F 0 0

//--- all.f
verilog/uart_bank_pkg.sv
verilog/byte_fifo.sv
verilog/uart_tx_channel.sv
verilog/write_decoder.sv
verilog/status_collector.sv
verilog/uart_tx_bank.sv
sim/uart_tx_bank_tb.sv

//--- Makefile
# Verilator build for the UART transmit bank.

TB = uart_tx_bank_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps --top-module uart_tx_bank -f all.f

obj_dir/V$(TB): all.f $(wildcard verilog/*.sv) sim/$(TB).sv
	verilator --binary --timing --assert --timescale 1ns/100ps --top-module $(TB) -f all.f

sim: obj_dir/V$(TB)
	./obj_dir/V$(TB) | tee $(LOG)
	grep -qx "test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
